// ==== design/vwrite_pkg.sv ====
`default_nettype none

package vwrite_pkg;

   // stream and buffer word
   localparam int DATA_W = 32;

   // buffer word address, top bit picks the ping-pong half
   localparam int ADDR_W = 10;

   // address generator counters
   localparam int PERIOD_W = 8;
   localparam int DELAY_W = 8;

   // external memory side
   localparam int AXI_ADDR_W = 32;
   localparam int LEN_W = 16;

   // byte step of the external address per beat
   localparam int BYTES_PER_WORD = 4;

   // store address generator
   typedef enum logic [1:0] {
      GEN_IDLE,
      GEN_DELAY,
      GEN_RUN
   } gen_state_t;

   // databus burst splitter
   typedef enum logic [1:0] {
      BURST_IDLE,
      BURST_REQUEST,
      BURST_DATA
   } burst_state_t;

endpackage

`default_nettype wire

// ==== design/buffer_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module buffer_ram (
   input  wire                           clk,
   input  wire                           we_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0] waddr_i,
   input  wire  [vwrite_pkg::DATA_W-1:0] wdata_i,
   input  wire                           re_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0] raddr_i,
   output logic [vwrite_pkg::DATA_W-1:0] rdata_o
);
   import vwrite_pkg::*;

   logic [DATA_W-1:0] mem [0:2**ADDR_W-1];

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
      // read data shows up one cycle after re_i
      if (re_i) begin
         rdata_o <= mem[raddr_i];
      end
   end

endmodule

`default_nettype wire

// ==== design/store_addr_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module store_addr_gen (
   input  wire                             clk,
   input  wire                             rst,
   input  wire                             run_i,
   input  wire  [vwrite_pkg::DELAY_W-1:0]  delay_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]   start_i,
   input  wire  [vwrite_pkg::PERIOD_W-1:0] per_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]   incr_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]   iter_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]   shift_i,
   output logic                            write_o,
   output logic [vwrite_pkg::ADDR_W-1:0]   addr_o,
   output logic                            done_o
);
   import vwrite_pkg::*;

   gen_state_t          state;
   logic [DELAY_W-1:0]  delay_cnt;
   logic [PERIOD_W-1:0] per_cnt;
   logic [ADDR_W-1:0]   iter_cnt;
   logic [ADDR_W-1:0]   addr;
   logic [ADDR_W-1:0]   base;
   logic                empty;
   logic                inner_last;
   logic                outer_last;

   // zero period or zero iterations means nothing to store
   assign empty      = (per_i == '0) || (iter_i == '0);
   assign inner_last = (per_cnt == per_i - 1'b1);
   assign outer_last = (iter_cnt == iter_i - 1'b1);

   assign write_o = (state == GEN_RUN) && !empty;
   assign addr_o  = addr;
   assign done_o  = (state == GEN_RUN) && (empty || (inner_last && outer_last));

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= GEN_IDLE;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         addr      <= '0;
         base      <= '0;
      end else if (run_i) begin
         per_cnt   <= '0;
         iter_cnt  <= '0;
         addr      <= start_i;
         base      <= start_i;
         delay_cnt <= delay_i;
         // first write lands delay_i + 1 cycles after the run pulse
         state     <= (delay_i == '0) ? GEN_RUN : GEN_DELAY;
      end else begin
         case (state)
            GEN_DELAY: begin
               if (delay_cnt == DELAY_W'(1)) begin
                  state <= GEN_RUN;
               end else begin
                  delay_cnt <= delay_cnt - 1'b1;
               end
            end
            GEN_RUN: begin
               if (done_o) begin
                  state <= GEN_IDLE;
               end else if (inner_last) begin
                  // next outer iteration starts from the shifted base
                  per_cnt  <= '0;
                  iter_cnt <= iter_cnt + 1'b1;
                  base     <= base + shift_i;
                  addr     <= base + shift_i;
               end else begin
                  per_cnt <= per_cnt + 1'b1;
                  addr    <= addr + incr_i;
               end
            end
            default: begin
               state <= GEN_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/buffer_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

module buffer_reader (
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           start_i,
   input  wire  [vwrite_pkg::LEN_W-1:0]  count_i,
   input  wire                           half_i,
   input  wire                           ping_pong_i,
   output logic                          mem_re_o,
   output logic [vwrite_pkg::ADDR_W-1:0] mem_raddr_o,
   input  wire  [vwrite_pkg::DATA_W-1:0] mem_rdata_i,
   output logic                          word_valid_o,
   output logic [vwrite_pkg::DATA_W-1:0] word_o,
   input  wire                           take_i
);
   import vwrite_pkg::*;

   logic [LEN_W-1:0]  to_issue;
   logic [ADDR_W-1:0] rd_addr;
   logic              in_flight;
   logic [1:0]        q_cnt;
   logic [DATA_W-1:0] q0;
   logic [DATA_W-1:0] q1;
   logic [1:0]        occupancy;
   logic              room;

   // queued words plus the one still coming back from memory
   assign occupancy = q_cnt + {1'b0, in_flight};
   assign room      = (occupancy < 2'd2) || take_i;

   assign mem_re_o    = (to_issue != '0) && room;
   assign mem_raddr_o = ping_pong_i ? {half_i, rd_addr[ADDR_W-2:0]} : rd_addr;

   assign word_valid_o = (q_cnt != 2'd0);
   assign word_o       = q0;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         to_issue  <= '0;
         rd_addr   <= '0;
         in_flight <= 1'b0;
         q_cnt     <= 2'd0;
      end else if (start_i) begin
         to_issue  <= count_i;
         rd_addr   <= '0;
         in_flight <= 1'b0;
         q_cnt     <= 2'd0;
      end else begin
         in_flight <= mem_re_o;
         if (mem_re_o) begin
            to_issue <= to_issue - 1'b1;
            rd_addr  <= rd_addr + 1'b1;
         end
         q_cnt <= q_cnt + {1'b0, in_flight} - {1'b0, take_i};
      end
   end

   // q0 is the head
   always_ff @(posedge clk) begin
      case ({in_flight, take_i})
         2'b10: begin
            if (q_cnt == 2'd0) begin
               q0 <= mem_rdata_i;
            end else begin
               q1 <= mem_rdata_i;
            end
         end
         2'b11: begin
            // a returning read leaves room for one queued word only
            q0 <= mem_rdata_i;
         end
         2'b01: begin
            q0 <= q1;
         end
         default: begin
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== design/databus_burst.sv ====
`timescale 1ns/100ps
`default_nettype none

module databus_burst (
   input  wire                                clk,
   input  wire                                rst,
   input  wire                                start_i,
   input  wire  [vwrite_pkg::AXI_ADDR_W-1:0]  ext_addr_i,
   input  wire  [vwrite_pkg::LEN_W-1:0]       count_i,
   input  wire  [vwrite_pkg::LEN_W-1:0]       length_i,
   input  wire                                word_valid_i,
   input  wire  [vwrite_pkg::DATA_W-1:0]      word_i,
   output logic                               take_o,
   input  wire                                ready_i,
   input  wire                                last_i,
   output logic                               valid_o,
   output logic [vwrite_pkg::AXI_ADDR_W-1:0]  addr_o,
   output logic [vwrite_pkg::DATA_W-1:0]      wdata_o,
   output logic [vwrite_pkg::DATA_W/8-1:0]    wstrb_o,
   output logic [vwrite_pkg::LEN_W-1:0]       len_o,
   output logic                               done_o
);
   import vwrite_pkg::*;

   burst_state_t          state;
   logic [AXI_ADDR_W-1:0] addr;
   logic [LEN_W-1:0]      remaining;
   logic [LEN_W-1:0]      cur_len;

   // burst size, capped by what is left
   function automatic logic [LEN_W-1:0] burst_len(input logic [LEN_W-1:0] len,
                                                  input logic [LEN_W-1:0] left);
      return (left < len) ? left : len;
   endfunction

   // request and data phases share the one valid line
   assign valid_o = (state == BURST_REQUEST) || ((state == BURST_DATA) && word_valid_i);
   assign take_o  = (state == BURST_DATA) && word_valid_i && ready_i;
   assign addr_o  = addr;
   assign len_o   = cur_len;
   assign wdata_o = word_i;
   assign wstrb_o = '1;

   // remaining already excludes the burst in flight
   assign done_o = take_o && last_i && (remaining == '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= BURST_IDLE;
         addr      <= '0;
         remaining <= '0;
         cur_len   <= '0;
      end else if (start_i) begin
         addr      <= ext_addr_i;
         remaining <= count_i;
         cur_len   <= burst_len(length_i, count_i);
         state     <= BURST_REQUEST;
      end else begin
         case (state)
            BURST_REQUEST: begin
               if (ready_i) begin
                  remaining <= remaining - cur_len;
                  state     <= BURST_DATA;
               end
            end
            BURST_DATA: begin
               if (take_o && last_i) begin
                  addr    <= addr + AXI_ADDR_W'(BYTES_PER_WORD * cur_len);
                  cur_len <= burst_len(length_i, remaining);
                  state   <= (remaining == '0) ? BURST_IDLE : BURST_REQUEST;
               end
            end
            default: begin
               state <= BURST_IDLE;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/vwrite_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module vwrite_unit (
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               run_i,
   input  wire                               running_i,
   output logic                              done_o,
   input  wire  [vwrite_pkg::DATA_W-1:0]     in_data_i,
   input  wire                               enabled_i,
   input  wire                               ping_pong_i,
   input  wire  [vwrite_pkg::AXI_ADDR_W-1:0] ext_addr_i,
   input  wire  [vwrite_pkg::LEN_W-1:0]      count_i,
   input  wire  [vwrite_pkg::LEN_W-1:0]      length_i,
   input  wire  [vwrite_pkg::DELAY_W-1:0]    delay_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]     start_i,
   input  wire  [vwrite_pkg::PERIOD_W-1:0]   per_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]     incr_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]     iter_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]     shift_i,
   input  wire                               databus_ready_i,
   output logic                              databus_valid_o,
   output logic [vwrite_pkg::AXI_ADDR_W-1:0] databus_addr_o,
   output logic [vwrite_pkg::DATA_W-1:0]     databus_wdata_o,
   output logic [vwrite_pkg::DATA_W/8-1:0]   databus_wstrb_o,
   output logic [vwrite_pkg::LEN_W-1:0]      databus_len_o,
   input  wire                               databus_last_i,
   output logic                              mem_we_o,
   output logic [vwrite_pkg::ADDR_W-1:0]     mem_waddr_o,
   output logic [vwrite_pkg::DATA_W-1:0]     mem_wdata_o,
   output logic                              mem_re_o,
   output logic [vwrite_pkg::ADDR_W-1:0]     mem_raddr_o,
   input  wire  [vwrite_pkg::DATA_W-1:0]     mem_rdata_i
);
   import vwrite_pkg::*;

   logic              store_done;
   logic              xfer_done;
   logic              pp_state;
   logic              xfer_start;
   logic              store_fin;
   logic              xfer_fin;
   logic              gen_write;
   logic [ADDR_W-1:0] gen_addr;
   logic              word_valid;
   logic [DATA_W-1:0] word;
   logic              take;

   // an empty transfer counts as already finished
   assign xfer_start = run_i && enabled_i && (count_i != '0);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         store_done <= 1'b1;
         xfer_done  <= 1'b1;
      end else if (run_i) begin
         store_done <= 1'b0;
         xfer_done  <= !xfer_start;
      end else if (running_i) begin
         if (store_fin) begin
            store_done <= 1'b1;
         end
         if (xfer_fin) begin
            xfer_done <= 1'b1;
         end
      end
   end

   assign done_o = store_done && xfer_done;

   // store half flips each run, transfer reads the other one
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (run_i) begin
         pp_state <= ping_pong_i ? !pp_state : 1'b0;
      end
   end

   assign mem_we_o    = gen_write;
   assign mem_waddr_o = ping_pong_i ? {pp_state, gen_addr[ADDR_W-2:0]} : gen_addr;
   assign mem_wdata_o = in_data_i;

   store_addr_gen store_gen_i (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .delay_i (delay_i),
      .start_i (start_i),
      .per_i   (per_i),
      .incr_i  (incr_i),
      .iter_i  (iter_i),
      .shift_i (shift_i),
      .write_o (gen_write),
      .addr_o  (gen_addr),
      .done_o  (store_fin)
   );

   buffer_reader reader_i (
      .clk          (clk),
      .rst          (rst),
      .start_i      (xfer_start),
      .count_i      (count_i),
      .half_i       (!pp_state),
      .ping_pong_i  (ping_pong_i),
      .mem_re_o     (mem_re_o),
      .mem_raddr_o  (mem_raddr_o),
      .mem_rdata_i  (mem_rdata_i),
      .word_valid_o (word_valid),
      .word_o       (word),
      .take_i       (take)
   );

   databus_burst burst_i (
      .clk          (clk),
      .rst          (rst),
      .start_i      (xfer_start),
      .ext_addr_i   (ext_addr_i),
      .count_i      (count_i),
      .length_i     (length_i),
      .word_valid_i (word_valid),
      .word_i       (word),
      .take_o       (take),
      .ready_i      (databus_ready_i),
      .last_i       (databus_last_i),
      .valid_o      (databus_valid_o),
      .addr_o       (databus_addr_o),
      .wdata_o      (databus_wdata_o),
      .wstrb_o      (databus_wstrb_o),
      .len_o        (databus_len_o),
      .done_o       (xfer_fin)
   );

endmodule

`default_nettype wire

// ==== design/vwrite_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module vwrite_top (
   input  wire                               clk,
   input  wire                               rst,
   input  wire                               run_i,
   input  wire                               running_i,
   output logic                              done_o,
   input  wire  [vwrite_pkg::DATA_W-1:0]     in_data_i,
   input  wire                               enabled_i,
   input  wire                               ping_pong_i,
   input  wire  [vwrite_pkg::AXI_ADDR_W-1:0] ext_addr_i,
   input  wire  [vwrite_pkg::LEN_W-1:0]      count_i,
   input  wire  [vwrite_pkg::LEN_W-1:0]      length_i,
   input  wire  [vwrite_pkg::DELAY_W-1:0]    delay_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]     start_i,
   input  wire  [vwrite_pkg::PERIOD_W-1:0]   per_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]     incr_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]     iter_i,
   input  wire  [vwrite_pkg::ADDR_W-1:0]     shift_i,
   input  wire                               databus_ready_i,
   output logic                              databus_valid_o,
   output logic [vwrite_pkg::AXI_ADDR_W-1:0] databus_addr_o,
   output logic [vwrite_pkg::DATA_W-1:0]     databus_wdata_o,
   output logic [vwrite_pkg::DATA_W/8-1:0]   databus_wstrb_o,
   output logic [vwrite_pkg::LEN_W-1:0]      databus_len_o,
   input  wire                               databus_last_i
);
   import vwrite_pkg::*;

   logic              mem_we;
   logic [ADDR_W-1:0] mem_waddr;
   logic [DATA_W-1:0] mem_wdata;
   logic              mem_re;
   logic [ADDR_W-1:0] mem_raddr;
   logic [DATA_W-1:0] mem_rdata;

   vwrite_unit unit_i (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run_i),
      .running_i       (running_i),
      .done_o          (done_o),
      .in_data_i       (in_data_i),
      .enabled_i       (enabled_i),
      .ping_pong_i     (ping_pong_i),
      .ext_addr_i      (ext_addr_i),
      .count_i         (count_i),
      .length_i        (length_i),
      .delay_i         (delay_i),
      .start_i         (start_i),
      .per_i           (per_i),
      .incr_i          (incr_i),
      .iter_i          (iter_i),
      .shift_i         (shift_i),
      .databus_ready_i (databus_ready_i),
      .databus_valid_o (databus_valid_o),
      .databus_addr_o  (databus_addr_o),
      .databus_wdata_o (databus_wdata_o),
      .databus_wstrb_o (databus_wstrb_o),
      .databus_len_o   (databus_len_o),
      .databus_last_i  (databus_last_i),
      .mem_we_o        (mem_we),
      .mem_waddr_o     (mem_waddr),
      .mem_wdata_o     (mem_wdata),
      .mem_re_o        (mem_re),
      .mem_raddr_o     (mem_raddr),
      .mem_rdata_i     (mem_rdata)
   );

   buffer_ram ram_i (
      .clk     (clk),
      .we_i    (mem_we),
      .waddr_i (mem_waddr),
      .wdata_i (mem_wdata),
      .re_i    (mem_re),
      .raddr_i (mem_raddr),
      .rdata_o (mem_rdata)
   );

endmodule

`default_nettype wire

// ==== tests/vwrite_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module vwrite_tb;
   import vwrite_pkg::*;

   localparam int NUM_RUNS = 6;

   logic                  clk = 1'b0;
   logic                  rst;
   logic                  run;
   logic                  running;
   logic                  done;
   logic [DATA_W-1:0]     in_data;
   logic                  enabled;
   logic                  ping_pong;
   logic [AXI_ADDR_W-1:0] ext_addr;
   logic [LEN_W-1:0]      count;
   logic [LEN_W-1:0]      length;
   logic [DELAY_W-1:0]    delay;
   logic [ADDR_W-1:0]     start;
   logic [PERIOD_W-1:0]   per;
   logic [ADDR_W-1:0]     incr;
   logic [ADDR_W-1:0]     iter;
   logic [ADDR_W-1:0]     shift;
   logic                  bus_ready;
   logic                  bus_valid;
   logic [AXI_ADDR_W-1:0] bus_addr;
   logic [DATA_W-1:0]     bus_wdata;
   logic [DATA_W/8-1:0]   bus_wstrb;
   logic [LEN_W-1:0]      bus_len;
   logic                  bus_last;

   // run 0 fills the whole buffer and runs 3 to 5 use ping-pong
   int cfg_pp     [NUM_RUNS] = '{0, 0, 0, 1, 1, 1};
   int cfg_en     [NUM_RUNS] = '{0, 1, 1, 1, 1, 1};
   int cfg_delay  [NUM_RUNS] = '{0, 5, 0, 2, 0, 7};
   int cfg_start  [NUM_RUNS] = '{0, 100, 0, 10, 10, 10};
   int cfg_per    [NUM_RUNS] = '{128, 6, 0, 8, 8, 8};
   int cfg_incr   [NUM_RUNS] = '{1, 3, 1, 5, 5, 5};
   int cfg_iter   [NUM_RUNS] = '{8, 4, 1, 6, 6, 6};
   int cfg_shift  [NUM_RUNS] = '{128, 50, 0, 120, 120, 120};
   int cfg_count  [NUM_RUNS] = '{16, 37, 300, 64, 64, 64};
   int cfg_length [NUM_RUNS] = '{1, 8, 16, 7, 7, 7};
   logic [AXI_ADDR_W-1:0] cfg_ext [NUM_RUNS] = '{32'h0000_0000, 32'h8000_0100,
      32'h1000_0040, 32'h2000_0000, 32'h2000_1000, 32'h2000_2000};

   logic [DATA_W-1:0]     shadow [0:(1 << ADDR_W) - 1];
   logic [DATA_W-1:0]     exp_words [$];
   logic [DATA_W-1:0]     cur_tag = '0;
   logic [DATA_W-1:0]     held_wdata;
   logic [AXI_ADDR_W-1:0] xfer_ext;
   bit                    tb_pp = 1'b0;
   bit                    xfer_active = 1'b0;
   bit                    in_burst = 1'b0;
   bit                    hold_beat = 1'b0;
   int                    xfer_count;
   int                    xfer_length;
   int                    burst_idx;
   int                    beats_total;
   int                    beat_cnt = 0;
   int                    burst_len = 0;
   int                    n_since_run = 0;
   int                    cycles = 0;
   int                    cycle_limit;

   vwrite_top dut_i (
      .clk             (clk),
      .rst             (rst),
      .run_i           (run),
      .running_i       (running),
      .done_o          (done),
      .in_data_i       (in_data),
      .enabled_i       (enabled),
      .ping_pong_i     (ping_pong),
      .ext_addr_i      (ext_addr),
      .count_i         (count),
      .length_i        (length),
      .delay_i         (delay),
      .start_i         (start),
      .per_i           (per),
      .incr_i          (incr),
      .iter_i          (iter),
      .shift_i         (shift),
      .databus_ready_i (bus_ready),
      .databus_valid_o (bus_valid),
      .databus_addr_o  (bus_addr),
      .databus_wdata_o (bus_wdata),
      .databus_wstrb_o (bus_wstrb),
      .databus_len_o   (bus_len),
      .databus_last_i  (bus_last)
   );

   always #20 clk = ~clk;

   task automatic stop_with_error(input string line);
      $display("%s", line);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped");
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         stop_with_error($sformatf("timeout: no finish within %0d cycles", cycle_limit));
      end
   end

   // request fields must hold while the slave stalls
   assert property (@(posedge clk) disable iff (rst)
      $past(bus_valid && !bus_ready) |->
         (bus_valid && bus_addr == $past(bus_addr) && bus_len == $past(bus_len)))
      else stop_with_error($sformatf("[FAIL] %0t: request moved while ready low", $time));

   // rough upper bound with store and transfer counted one after the other
   function automatic int run_cycles(input int r);
      int n;
      n = cfg_delay[r] + cfg_per[r] * cfg_iter[r] + 12;
      if (cfg_en[r] != 0) begin
         n += 2 * cfg_count[r] + 3 * (cfg_count[r] / cfg_length[r] + 1);
      end
      return n;
   endfunction

   function automatic int store_addr(input int r, input int i, input int j);
      int a;
      a = cfg_start[r] + i * cfg_shift[r] + j * cfg_incr[r];
      if (cfg_pp[r] != 0) begin
         return int'(tb_pp) * (1 << (ADDR_W - 1)) + a % (1 << (ADDR_W - 1));
      end
      return a % (1 << ADDR_W);
   endfunction

   task automatic check_request();
      int                    exp_len;
      logic [AXI_ADDR_W-1:0] exp_addr;
      exp_len = xfer_count - burst_idx * xfer_length;
      if (exp_len > xfer_length) begin
         exp_len = xfer_length;
      end
      exp_addr = xfer_ext + AXI_ADDR_W'(BYTES_PER_WORD * xfer_length * burst_idx);
      assert (bus_addr == exp_addr)
         else stop_with_error($sformatf("[FAIL] %0t: burst %0d addr %h, expected %h",
                                        $time, burst_idx, bus_addr, exp_addr));
      assert (int'(bus_len) == exp_len)
         else stop_with_error($sformatf("[FAIL] %0t: burst %0d len %0d, expected %0d",
                                        $time, burst_idx, bus_len, exp_len));
      in_burst = 1'b1;
      beat_cnt = 0;
      burst_len = exp_len;
      burst_idx++;
   endtask

   task automatic check_beat();
      logic [DATA_W-1:0] exp_word;
      assert (exp_words.size() != 0)
         else stop_with_error($sformatf("[FAIL] %0t: beat beyond the word count", $time));
      exp_word = exp_words.pop_front();
      assert (bus_wdata == exp_word && bus_wstrb == '1)
         else stop_with_error($sformatf("[FAIL] %0t: beat %0d wdata %h, expected %h",
                                        $time, beats_total, bus_wdata, exp_word));
      beat_cnt++;
      beats_total++;
      if (beat_cnt == burst_len) begin
         in_burst = 1'b0;
      end
      if (beats_total == xfer_count) begin
         xfer_active = 1'b0;
      end
   endtask

   // negedge sees the values the next rising edge will sample
   always @(negedge clk) begin
      if (!rst) begin
         if (hold_beat) begin
            assert (bus_wdata == held_wdata)
               else stop_with_error($sformatf("[FAIL] %0t: wdata moved while ready low", $time));
         end
         assert (!bus_valid || xfer_active)
            else stop_with_error($sformatf("[FAIL] %0t: valid with no transfer due", $time));
         assert (!(done && xfer_active && !run))
            else stop_with_error($sformatf("[FAIL] %0t: done high before last beat", $time));
         if (bus_valid && bus_ready) begin
            if (in_burst) begin
               check_beat();
            end else begin
               check_request();
            end
         end
         hold_beat = in_burst && bus_valid && !bus_ready;
         held_wdata = bus_wdata;
      end
   end

   // slave model
   initial begin
      void'($urandom(32'h353d));
      bus_ready = 1'b0;
      bus_last = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         bus_ready = ($urandom % 100) < 70;
         bus_last = in_burst && (beat_cnt == burst_len - 1);
      end
   end

   task automatic tick();
      @(posedge clk);
      #1;
      run = 1'b0;
      n_since_run++;
      in_data = cur_tag + DATA_W'(n_since_run);
   endtask

   task automatic do_run(input int r);
      int i;
      int j;
      int a;
      tb_pp = (cfg_pp[r] != 0) ? !tb_pp : 1'b0;
      // the transfer sees what earlier runs left in the other half
      exp_words.delete();
      for (i = 0; i < cfg_count[r] && cfg_en[r] != 0; i++) begin
         a = (cfg_pp[r] != 0) ? (1 - int'(tb_pp)) * (1 << (ADDR_W - 1)) + i : i;
         exp_words.push_back(shadow[a]);
      end
      cur_tag = DATA_W'(r + 1) << 24;
      for (i = 0; i < cfg_iter[r]; i++) begin
         for (j = 0; j < cfg_per[r]; j++) begin
            shadow[store_addr(r, i, j)] =
               cur_tag + DATA_W'(cfg_delay[r] + 1 + i * cfg_per[r] + j);
         end
      end
      tick();
      run = 1'b1;
      running = 1'b1;
      enabled = (cfg_en[r] != 0);
      ping_pong = (cfg_pp[r] != 0);
      ext_addr = cfg_ext[r];
      count = LEN_W'(cfg_count[r]);
      length = LEN_W'(cfg_length[r]);
      delay = DELAY_W'(cfg_delay[r]);
      start = ADDR_W'(cfg_start[r]);
      per = PERIOD_W'(cfg_per[r]);
      incr = ADDR_W'(cfg_incr[r]);
      iter = ADDR_W'(cfg_iter[r]);
      shift = ADDR_W'(cfg_shift[r]);
      n_since_run = 0;
      in_data = cur_tag;
      xfer_active = (cfg_en[r] != 0) && (cfg_count[r] != 0);
      xfer_count = cfg_count[r];
      xfer_length = cfg_length[r];
      xfer_ext = cfg_ext[r];
      burst_idx = 0;
      beats_total = 0;
      tick();
      assert (!done) else stop_with_error($sformatf("[FAIL] %0t: done stayed high", $time));
      while (!done) begin
         tick();
      end
      assert (n_since_run >= cfg_delay[r] + cfg_per[r] * cfg_iter[r] + 1)
         else stop_with_error($sformatf("[FAIL] %0t: run %0d done before its stores",
                                        $time, r));
      assert (!xfer_active && exp_words.size() == 0 && beats_total == cfg_count[r] * cfg_en[r])
         else stop_with_error($sformatf("[FAIL] %0t: run %0d ended after %0d beats",
                                        $time, r, beats_total));
      running = 1'b0;
      repeat (3) tick();
   endtask

   initial begin
      int r;
      rst = 1'b1;
      run = 1'b0;
      running = 1'b0;
      in_data = '0;
      enabled = 1'b0;
      ping_pong = 1'b0;
      ext_addr = '0;
      count = '0;
      length = '0;
      delay = '0;
      start = '0;
      per = '0;
      incr = '0;
      iter = '0;
      shift = '0;
      cycle_limit = 0;
      for (r = 0; r < NUM_RUNS; r++) begin
         cycle_limit += run_cycles(r);
      end
      cycle_limit = 4 * cycle_limit;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      assert (done === 1'b1 && bus_valid === 1'b0)
         else stop_with_error($sformatf("[FAIL] %0t: wrong done or valid after reset", $time));
      for (r = 0; r < NUM_RUNS; r++) begin
         do_run(r);
      end
      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/vwrite_pkg.sv
design/buffer_ram.sv
design/store_addr_gen.sv
design/buffer_reader.sv
design/databus_burst.sv
design/vwrite_unit.sv
design/vwrite_top.sv
tests/vwrite_tb.sv

// ==== Makefile ====
# Verilator build and run of the write unit testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module vwrite_tb \
		-Mdir obj_dir -f vlog.f
	./obj_dir/Vvwrite_tb 2>&1 | tee $(LOG)
	@grep -q "^NO ERRORS$$" $(LOG) || (echo "simulation failed"; exit 1)
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
